//--- bench/tb_adc.sv
`default_nettype none

module tb_adc import adc_pkg::*;;

  timeunit 1ns;
  timeprecision 1ns;

  localparam int PULSES = 4;
  localparam int DEPTH  = 4;

  logic clk;
  logic rst_n;
  logic [IAGC_STATUS_W-1:0] iagc_status;
  adc_sample_t adc_data;
  logic dco;
  logic test_mode;
  logic enable_acq;
  relay_cfg_t relay_cfg;
  relay_coils_t coils;
  adc_word_t data_out;
  logic data_valid;
  logic data_ready;
  logic init_done;
  logic overflow;

  adc_word_t model_q[$];  // Words the DUT should still deliver with the oldest first.
  string test_name;
  int errors = 0;
  int tests_passed = 0;
  int tests_failed = 0;
  int cycle = 0;
  int last_ch2_cycle = 0;
  int pops = 0;
  int ready_prob = 100;
  bit check_latency = 0;
  bit stalled = 0;
  adc_word_t held_word;

  tb_clock_gen #(.PERIOD_NS(100), .RESET_CYCLES(5)) u_clock_gen (
    .o_clk   (clk),
    .o_rst_n (rst_n)
  );

  adc #(.RELAY_PULSE_CYCLES(PULSES), .FIFO_DEPTH(DEPTH)) u_adc (
    .i_sys_clock          (clk),
    .i_rst_n              (rst_n),
    .i_iagc_status        (iagc_status),
    .i_adc_data           (adc_data),
    .i_adc_dco            (dco),
    .i_test_mode          (test_mode),
    .i_enable_acquisition (enable_acq),
    .i_relay_cfg          (relay_cfg),
    .o_coils              (coils),
    .o_adc_data           (data_out),
    .o_adc_data_valid     (data_valid),
    .i_adc_data_ready     (data_ready),
    .o_adc_init_done      (init_done),
    .o_data_overflow      (overflow)
  );

  // Each sample moves up two bits inside its half-word, channel 1 in the upper half.
  function automatic adc_word_t pack_pair(adc_sample_t ch1, adc_sample_t ch2);
    adc_word_t w;
    w[31:16] = {2'b00, ch1} << 2;
    w[15:0]  = {2'b00, ch2} << 2;
    return w;
  endfunction

  function automatic relay_coils_t coil_pattern(relay_cfg_t cfg, relay_cfg_t sel, bit first);
    relay_coils_t c;
    c = '0;
    c.ch1_coupling_h = sel.ch1_dc && cfg.ch1_dc;
    c.ch1_coupling_l = sel.ch1_dc && !cfg.ch1_dc;
    c.ch2_coupling_h = sel.ch2_dc && cfg.ch2_dc;
    c.ch2_coupling_l = sel.ch2_dc && !cfg.ch2_dc;
    c.ch1_gain_h = sel.ch1_high_gain && cfg.ch1_high_gain;
    c.ch1_gain_l = sel.ch1_high_gain && !cfg.ch1_high_gain;
    c.ch2_gain_h = sel.ch2_high_gain && cfg.ch2_high_gain;
    c.ch2_gain_l = sel.ch2_high_gain && !cfg.ch2_high_gain;
    c.relay_com_h = first;
    return c;
  endfunction

  task automatic value_error(input string what, input logic [31:0] exp, input logic [31:0] act);
    $display("[ERROR] %s: %s expected %h, actual %h", test_name, what, exp, act);
    errors++;
  endtask

  task automatic plain_error(input string what);
    $display("%s: %s", test_name, what);
    errors++;
  endtask

  // Compare a word that transfers on the coming rising edge.
  task automatic take_word();
    adc_word_t exp;
    pops++;
    if (model_q.size() == 0) begin
      plain_error("the DUT delivered a word that no pair produced");
      return;
    end
    exp = model_q.pop_front();
    assert (data_out == exp) else value_error("word", exp, data_out);
    if (check_latency) begin
      assert (cycle - last_ch2_cycle == 3) else value_error("latency", 3, cycle - last_ch2_cycle);
    end
  endtask

  // Each clock checks outputs at the falling edge and then drives new inputs.
  task automatic tick(input logic strobe, input adc_sample_t sample);
    logic rdy;
    @(negedge clk);
    cycle++;
    if (stalled) begin
      assert (data_valid && data_out == held_word)
        else value_error("stalled word", held_word, data_out);
    end
    if (!init_done) begin
      assert (!data_valid) else plain_error("data valid came before init done");
    end
    rdy = ($urandom_range(99) < ready_prob);
    dco = strobe;
    adc_data = sample;
    data_ready = rdy;
    if (data_valid && rdy) take_word();
    stalled = data_valid && !rdy;
    held_word = data_out;
  endtask

  task automatic send_pair(input adc_sample_t ch1, input adc_sample_t ch2, input int gap_max);
    tick(1'b1, ch1);
    repeat ($urandom_range(gap_max)) tick(1'b0, '0);
    tick(1'b1, ch2);
    last_ch2_cycle = cycle;
  endtask

  task automatic send_random_pair(input int gap_max, input bit expect_word);
    adc_sample_t a;
    adc_sample_t b;
    a = adc_sample_t'($urandom);
    b = adc_sample_t'($urandom);
    send_pair(a, b, gap_max);
    if (expect_word) model_q.push_back(pack_pair(a, b));
  endtask

  task automatic drain(input int limit);
    int t;
    t = 0;
    tick(1'b0, '0);
    while ((model_q.size() != 0 || data_valid) && t < limit) begin
      tick(1'b0, '0);
      t++;
    end
    if (t >= limit) plain_error("timed out waiting for the output to drain");
    if (model_q.size() != 0) plain_error("words were lost");
  endtask

  // Wait for a coil pulse and check its pattern and length.
  task automatic watch_relays(input relay_coils_t exp, input bit first);
    int t;
    int n;
    t = 0;
    n = 0;
    while (coils == '0 && t < 50) begin
      tick(1'b0, '0);
      t++;
    end
    if (t >= 50) plain_error("timed out waiting for a coil pulse");
    assert (coils == exp) else value_error("coils", 32'(exp), 32'(coils));
    while (coils == exp && coils != '0 && n < PULSES + 4) begin
      if (first) begin
        assert (!init_done) else plain_error("init done rose during the coil pulses");
      end
      n++;
      tick(1'b0, '0);
    end
    assert (n == PULSES) else value_error("pulse length", PULSES, n);
    assert (coils == '0) else value_error("coils after pulse", 0, 32'(coils));
    assert (init_done) else plain_error("init done is low after the coil pulses");
  endtask

  task automatic finish_test();
    static int last_errors = 0;
    if (errors == last_errors) begin
      $display("%s: PASS", test_name);
      tests_passed++;
    end else begin
      $display("%s: FAIL", test_name);
      tests_failed++;
    end
    last_errors = errors;
  endtask

  initial begin
    relay_cfg_t new_cfg;
    adc_sample_t ramp;
    int wait_cycles;
    void'($urandom(32'ha126_88bf));
    iagc_status = '0;
    adc_data = '0;
    dco = 1'b0;
    test_mode = 1'b0;
    enable_acq = 1'b1;
    relay_cfg = 4'b1001;
    data_ready = 1'b1;

    test_name = "relay_init";
    wait_cycles = 0;
    while (rst_n !== 1'b1 && wait_cycles < 20) begin
      @(negedge clk);
      wait_cycles++;
    end
    if (rst_n !== 1'b1) plain_error("reset was never released");
    watch_relays(coil_pattern(relay_cfg, 4'b1111, 1'b1), 1'b1);
    finish_test();

    test_name = "ordered_words";
    check_latency = 1;
    repeat (8) begin
      send_random_pair(2, 1'b1);
      drain(20);
    end
    check_latency = 0;
    finish_test();

    test_name = "ready_stalls";
    ready_prob = 75;
    repeat (16) begin
      send_random_pair(3, 1'b1);
      repeat ($urandom_range(2)) tick(1'b0, '0);
    end
    ready_prob = 100;
    drain(100);
    assert (!overflow) else plain_error("overflow set while stalls were light");
    finish_test();

    test_name = "overflow";
    ready_prob = 0;
    repeat (DEPTH + 3) send_random_pair(1, model_q.size() < DEPTH);
    repeat (4) tick(1'b0, '0);
    assert (overflow) else value_error("overflow", 1, overflow);
    pops = 0;
    ready_prob = 100;
    drain(50);
    assert (pops == DEPTH) else value_error("drained words", DEPTH, pops);
    assert (overflow) else plain_error("overflow flag did not stay set");
    finish_test();

    test_name = "test_mode_relays_iagc";
    test_mode = 1'b1;
    ramp = '0;
    repeat (3) begin
      send_random_pair(1, 1'b0);
      model_q.push_back(pack_pair(ramp, ~ramp));
      ramp = ramp + 14'sd1;
    end
    drain(30);
    test_mode = 1'b0;
    new_cfg = relay_cfg ^ 4'b1000;
    relay_cfg = new_cfg;
    watch_relays(coil_pattern(new_cfg, 4'b1000, 1'b0), 1'b0);
    tick(1'b1, adc_sample_t'($urandom));  // Lone channel-1 sample.
    tick(1'b0, '0);
    iagc_status = IAGC_STATUS_RESET;
    repeat (3) send_random_pair(1, 1'b0);
    repeat (4) begin
      tick(1'b0, '0);
      assert (!data_valid) else plain_error("output appeared while the IAGC held reset");
    end
    iagc_status = '0;
    send_random_pair(1, 1'b1);
    drain(20);
    finish_test();

    $display("tests: %0d passed, %0d failed, %0d errors", tests_passed, tests_failed, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  initial begin
    #(2_000_000);
    $display("Timeout: the simulation did not reach its end.");
    $display("sim failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- bench/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 5
) (
  output logic o_clk,
  output logic o_rst_n
);

  timeunit 1ns;
  timeprecision 1ns;

  initial begin
    o_clk = 1'b0;
    forever #(PERIOD_NS / 2) o_clk = ~o_clk;
  end

  // Reset is released on a falling edge like every other input.
  initial begin
    o_rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge o_clk);
    @(negedge o_clk);
    o_rst_n = 1'b1;
  end

endmodule

`default_nettype wire

//--- build.f
logic/adc_pkg.sv
logic/adc_front_end.sv
logic/adc_sample_packer.sv
logic/adc_stream_fifo.sv
logic/adc.sv
bench/tb_clock_gen.sv
bench/tb_adc.sv

//--- logic/adc.sv
`default_nettype none

module adc import adc_pkg::*; #(
  parameter int RELAY_PULSE_CYCLES = 16,
  parameter int FIFO_DEPTH         = 8
) (
  input  wire                     i_sys_clock,
  input  wire                     i_rst_n,
  input  wire [IAGC_STATUS_W-1:0] i_iagc_status,
  input  wire adc_sample_t        i_adc_data,
  input  wire                     i_adc_dco,
  input  wire                     i_test_mode,
  input  wire                     i_enable_acquisition,
  input  wire relay_cfg_t         i_relay_cfg,
  output relay_coils_t            o_coils,
  output adc_word_t               o_adc_data,
  output logic                    o_adc_data_valid,
  input  wire                     i_adc_data_ready,
  output logic                    o_adc_init_done,
  output logic                    o_data_overflow
);

  adc_pair_t pair;
  logic      pair_valid;
  adc_word_t word;
  logic      word_valid;

  adc_front_end #(
    .RELAY_PULSE_CYCLES (RELAY_PULSE_CYCLES)
  ) u_front_end (
    .i_sys_clock          (i_sys_clock),
    .i_rst_n              (i_rst_n),
    .i_iagc_status        (i_iagc_status),
    .i_adc_data           (i_adc_data),
    .i_adc_dco            (i_adc_dco),
    .i_test_mode          (i_test_mode),
    .i_enable_acquisition (i_enable_acquisition),
    .i_relay_cfg          (i_relay_cfg),
    .o_pair               (pair),
    .o_pair_valid         (pair_valid),
    .o_coils              (o_coils),
    .o_init_done          (o_adc_init_done)
  );

  adc_sample_packer u_sample_packer (
    .i_sys_clock  (i_sys_clock),
    .i_rst_n      (i_rst_n),
    .i_pair       (pair),
    .i_pair_valid (pair_valid),
    .o_word       (word),
    .o_word_valid (word_valid)
  );

  adc_stream_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_stream_fifo (
    .i_sys_clock     (i_sys_clock),
    .i_rst_n         (i_rst_n),
    .i_word          (word),
    .i_word_valid    (word_valid),
    .o_data          (o_adc_data),
    .o_data_valid    (o_adc_data_valid),
    .i_data_ready    (i_adc_data_ready),
    .o_data_overflow (o_data_overflow)
  );

endmodule

`default_nettype wire

//--- logic/adc_front_end.sv
`default_nettype none

module adc_front_end import adc_pkg::*; #(
  parameter int RELAY_PULSE_CYCLES = 16
) (
  input  wire                     i_sys_clock,
  input  wire                     i_rst_n,
  input  wire [IAGC_STATUS_W-1:0] i_iagc_status,
  input  wire adc_sample_t        i_adc_data,
  input  wire                     i_adc_dco,
  input  wire                     i_test_mode,
  input  wire                     i_enable_acquisition,
  input  wire relay_cfg_t         i_relay_cfg,
  output adc_pair_t               o_pair,
  output logic                    o_pair_valid,
  output relay_coils_t            o_coils,
  output logic                    o_init_done
);

  localparam int PULSE_CNT_W = $clog2(RELAY_PULSE_CYCLES + 1);

  logic                   iagc_hold;
  logic                   acq_on;
  logic                   ch2_phase;  // High while waiting for the channel-2 sample.
  adc_sample_t            ch1_hold;
  adc_sample_t            ramp_cnt;
  logic                   seq_busy;
  logic [PULSE_CNT_W-1:0] pulse_cnt;
  relay_cfg_t             applied_cfg;
  relay_cfg_t             pulse_mask;

  assign iagc_hold = (i_iagc_status == IAGC_STATUS_RESET);
  assign acq_on    = o_init_done && i_enable_acquisition;

  always_ff @(posedge i_sys_clock) begin
    if (!i_rst_n || iagc_hold) begin
      ch2_phase    <= 1'b0;
      o_pair_valid <= 1'b0;
      ramp_cnt     <= '0;
    end else begin
      o_pair_valid <= 1'b0;
      if (!acq_on) begin
        ch2_phase <= 1'b0;  // Next pair starts again at channel 1.
      end else if (i_adc_dco) begin
        ch2_phase <= !ch2_phase;
        if (ch2_phase) begin
          o_pair_valid <= 1'b1;
          if (i_test_mode) ramp_cnt <= ramp_cnt + 14'sd1;
        end
      end
    end
  end

  // Sample payload.
  always_ff @(posedge i_sys_clock) begin
    if (i_adc_dco && !ch2_phase) ch1_hold <= i_adc_data;
    if (i_adc_dco && ch2_phase) begin
      if (i_test_mode) begin
        o_pair.ch1 <= ramp_cnt;
        o_pair.ch2 <= ~ramp_cnt;
      end else begin
        o_pair.ch1 <= ch1_hold;
        o_pair.ch2 <= i_adc_data;
      end
    end
  end

  // Relay sequencer. The first run after reset pulses every relay.
  always_ff @(posedge i_sys_clock) begin
    if (!i_rst_n) begin
      seq_busy    <= 1'b0;
      pulse_cnt   <= '0;
      applied_cfg <= '0;
      pulse_mask  <= '0;
      o_init_done <= 1'b0;
    end else if (seq_busy) begin
      pulse_cnt <= pulse_cnt - 1'b1;
      if (pulse_cnt == '0) begin
        seq_busy    <= 1'b0;
        o_init_done <= 1'b1;
      end
    end else if (!o_init_done || (i_relay_cfg != applied_cfg)) begin
      seq_busy    <= 1'b1;
      pulse_cnt   <= PULSE_CNT_W'(RELAY_PULSE_CYCLES - 1);
      applied_cfg <= i_relay_cfg;
      pulse_mask  <= o_init_done ? (i_relay_cfg ^ applied_cfg) : '1;
    end
  end

  // The H coil sets DC coupling or high gain, the L coil the opposite.
  always_comb begin
    o_coils                = '0;
    o_coils.ch1_coupling_h = seq_busy && pulse_mask.ch1_dc && applied_cfg.ch1_dc;
    o_coils.ch1_coupling_l = seq_busy && pulse_mask.ch1_dc && !applied_cfg.ch1_dc;
    o_coils.ch2_coupling_h = seq_busy && pulse_mask.ch2_dc && applied_cfg.ch2_dc;
    o_coils.ch2_coupling_l = seq_busy && pulse_mask.ch2_dc && !applied_cfg.ch2_dc;
    o_coils.ch1_gain_h = seq_busy && pulse_mask.ch1_high_gain && applied_cfg.ch1_high_gain;
    o_coils.ch1_gain_l = seq_busy && pulse_mask.ch1_high_gain && !applied_cfg.ch1_high_gain;
    o_coils.ch2_gain_h = seq_busy && pulse_mask.ch2_high_gain && applied_cfg.ch2_high_gain;
    o_coils.ch2_gain_l = seq_busy && pulse_mask.ch2_high_gain && !applied_cfg.ch2_high_gain;
    o_coils.relay_com_h = seq_busy && !o_init_done;  // Only during the power-up run.
  end

endmodule

`default_nettype wire

//--- logic/adc_pkg.sv
`default_nettype none

package adc_pkg;

  // Converter and stream widths.
  localparam int ADC_SAMPLE_W   = 14;
  localparam int ADC_WORD_W     = 32;
  localparam int IAGC_STATUS_W  = 4;

  // Zero bits below each left-justified sample in its half-word.
  localparam int ADC_PAD_W = ADC_WORD_W / 2 - ADC_SAMPLE_W;

  // Status code from the IAGC block that holds the capture path in reset.
  localparam logic [IAGC_STATUS_W-1:0] IAGC_STATUS_RESET = 4'hF;

  typedef logic signed [ADC_SAMPLE_W-1:0] adc_sample_t;

  // One channel-1/channel-2 sample pair.
  typedef struct packed {
    adc_sample_t ch1;
    adc_sample_t ch2;
  } adc_pair_t;

  typedef logic [ADC_WORD_W-1:0] adc_word_t;

  // A set bit in the requested relay positions picks DC coupling or high gain.
  typedef struct packed {
    logic ch1_dc;
    logic ch1_high_gain;
    logic ch2_dc;
    logic ch2_high_gain;
  } relay_cfg_t;

  // Coil drives of the latching relays.
  typedef struct packed {
    logic ch1_coupling_h;
    logic ch1_coupling_l;
    logic ch2_coupling_h;
    logic ch2_coupling_l;
    logic ch1_gain_h;
    logic ch1_gain_l;
    logic ch2_gain_h;
    logic ch2_gain_l;
    logic relay_com_h;
    logic relay_com_l;
  } relay_coils_t;

endpackage

`default_nettype wire

//--- logic/adc_sample_packer.sv
`default_nettype none

module adc_sample_packer import adc_pkg::*; (
  input  wire            i_sys_clock,
  input  wire            i_rst_n,
  input  wire adc_pair_t i_pair,
  input  wire            i_pair_valid,
  output adc_word_t      o_word,
  output logic           o_word_valid
);

  adc_word_t packed_word;

  // Each sample is left-justified in its half-word with channel 1 on top.
  assign packed_word = {i_pair.ch1, {ADC_PAD_W{1'b0}}, i_pair.ch2, {ADC_PAD_W{1'b0}}};

  always_ff @(posedge i_sys_clock) begin
    if (!i_rst_n) begin
      o_word_valid <= 1'b0;
    end else begin
      o_word_valid <= i_pair_valid;
    end
  end

  // The word register loads only on a new pair.
  always_ff @(posedge i_sys_clock) begin
    if (i_pair_valid) o_word <= packed_word;
  end

endmodule

`default_nettype wire

//--- logic/adc_stream_fifo.sv
`default_nettype none

module adc_stream_fifo import adc_pkg::*; #(
  parameter int FIFO_DEPTH = 8
) (
  input  wire            i_sys_clock,
  input  wire            i_rst_n,
  input  wire adc_word_t i_word,
  input  wire            i_word_valid,
  output adc_word_t      o_data,
  output logic           o_data_valid,
  input  wire            i_data_ready,
  output logic           o_data_overflow
);

  localparam int ADDR_W = $clog2(FIFO_DEPTH);

  adc_word_t       mem [FIFO_DEPTH];
  logic [ADDR_W:0] wr_ptr;  // Top bit flips on each wrap.
  logic [ADDR_W:0] rd_ptr;
  logic            full;
  logic            empty;
  logic            do_write;
  logic            do_read;

  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                 (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);

  assign do_write = i_word_valid && !full;  // A word that finds the buffer full is lost.
  assign do_read  = o_data_valid && i_data_ready;

  assign o_data_valid = !empty;
  assign o_data       = mem[rd_ptr[ADDR_W-1:0]];

  always_ff @(posedge i_sys_clock) begin
    if (!i_rst_n) begin
      wr_ptr          <= '0;
      rd_ptr          <= '0;
      o_data_overflow <= 1'b0;
    end else begin
      if (do_write) wr_ptr <= wr_ptr + 1'b1;
      if (do_read) rd_ptr <= rd_ptr + 1'b1;
      if (i_word_valid && full) o_data_overflow <= 1'b1;  // Sticky until reset.
    end
  end

  always_ff @(posedge i_sys_clock) begin
    if (do_write) mem[wr_ptr[ADDR_W-1:0]] <= i_word;
  end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# Builds and runs the ADC front-end testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_adc -f build.f -o vsim
if [ $? -ne 0 ]; then
  echo "Verilator build failed."
  exit 1
fi

./obj_dir/vsim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status."
  exit 1
fi

if grep -qx "sim passed" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG."
exit 1
